//--- src.f
rtl/fetch_pkg.sv
rtl/bus_pkg.sv
rtl/pc_gen.sv
rtl/icache_fetch.sv
rtl/axil_read_master.sv
rtl/fetch_top.sv
test/tb_axil_mem.sv
test/tb_fetch_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= src.f
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
OBJ_DIR   ?= obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_fetch_top.sv
module tb_fetch_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 100;
  localparam int HS_BUDGET  = 2000;
  localparam int CYC_PER_HS = 10;

  logic             clk;
  logic             rst;
  logic             redirect;
  fetch_pkg::addr_t redirect_pc;
  logic             out_valid;
  logic             out_ready;
  fetch_pkg::inst_t out_inst;
  fetch_pkg::addr_t out_pc;
  logic             out_err;
  fetch_pkg::addr_t araddr;
  logic [2:0]       arprot;
  logic             arvalid;
  logic             arready;
  bus_pkg::data_t   rdata;
  bus_pkg::resp_t   rresp;
  logic             rvalid;
  logic             rready;
  int               ar_count;
  fetch_pkg::addr_t ar_addr;

  logic [31:0]      rng;
  int               errors = 0;
  int               hs_count = 0;
  int               miss_count = 0;
  int               conflict_count = 0;
  int               fence_count = 0;
  int               slverr_count = 0;
  int               stall_count = 0;

  // -------------------------------------------------------------------
  // Reference model state
  // -------------------------------------------------------------------
  fetch_pkg::addr_t            exp_pc = fetch_pkg::RESET_PC;
  logic                        pend = 1'b0;
  fetch_pkg::addr_t            pend_pc = '0;
  logic [fetch_pkg::LINES-1:0] shadow_valid = '0;
  fetch_pkg::tag_t             shadow_tag [fetch_pkg::LINES];
  int                          ar_seen = 0;
  logic                        stalled = 1'b0;
  fetch_pkg::inst_t            hold_inst;
  fetch_pkg::addr_t            hold_pc;
  logic                        hold_err;
  int                          hold_ar;

  fetch_top dut0 (
    .clk              (clk),
    .rst              (rst),
    .redirect_i       (redirect),
    .redirect_pc_i    (redirect_pc),
    .out_valid_o      (out_valid),
    .out_ready_i      (out_ready),
    .out_inst_o       (out_inst),
    .out_pc_o         (out_pc),
    .out_err_o        (out_err),
    .m_axil_araddr_o  (araddr),
    .m_axil_arprot_o  (arprot),
    .m_axil_arvalid_o (arvalid),
    .m_axil_arready_i (arready),
    .m_axil_rdata_i   (rdata),
    .m_axil_rresp_i   (rresp),
    .m_axil_rvalid_i  (rvalid),
    .m_axil_rready_o  (rready)
  );

  tb_axil_mem mem0 (
    .clk        (clk),
    .rst        (rst),
    .araddr_i   (araddr),
    .arvalid_i  (arvalid),
    .arready_o  (arready),
    .rdata_o    (rdata),
    .rresp_o    (rresp),
    .rvalid_o   (rvalid),
    .rready_i   (rready),
    .ar_count_o (ar_count),
    .ar_addr_o  (ar_addr)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic fetch_pkg::inst_t word_at(input fetch_pkg::addr_t a);
    if (a[6:2] == 5'd19)
      return fetch_pkg::FENCE_I;
    return xorshift32(a ^ 32'd78);
  endfunction

  function automatic logic err_range(input fetch_pkg::addr_t a);
    return a[31:5] == 27'h400_0006;
  endfunction

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, got);
    errors++;
  endtask

  task automatic check_fetch();
    fetch_pkg::idx_t idx;
    fetch_pkg::tag_t tag;
    logic            hit;
    idx = exp_pc[4:2];
    tag = exp_pc[31:5];
    hit = shadow_valid[idx] && (shadow_tag[idx] == tag);
    if (out_pc != exp_pc)
      report_value("out_pc_o", out_pc, exp_pc);
    if (out_inst != word_at(exp_pc))
      report_value("out_inst_o", out_inst, word_at(exp_pc));
    if (out_err != err_range(exp_pc))
      report_value("out_err_o", 32'(out_err), 32'(err_range(exp_pc)));
    if (ar_count - ar_seen != (hit ? 0 : 1))
      report_value("ar_count", 32'(ar_count - ar_seen), hit ? 32'd0 : 32'd1);
    else if (!hit && ar_addr != exp_pc)
      report_value("m_axil_araddr_o", ar_addr, exp_pc);
    ar_seen = ar_count;
    if (!hit)
      miss_count++;
    if (!hit && shadow_valid[idx])
      conflict_count++; // Same index, other tag.
    if (err_range(exp_pc))
      slverr_count++;
    else if (!hit)
    begin
      shadow_valid[idx] = 1'b1;
      shadow_tag[idx]   = tag;
    end
    if (word_at(exp_pc) == fetch_pkg::FENCE_I)
    begin
      shadow_valid = '0;
      fence_count++;
    end
    hs_count++;
  endtask

  task automatic check_hold();
    if (!out_valid)
      report_value("out_valid_o", 32'd0, 32'd1);
    if (out_inst != hold_inst)
      report_value("out_inst_o", out_inst, hold_inst);
    if (out_pc != hold_pc)
      report_value("out_pc_o", out_pc, hold_pc);
    if (out_err != hold_err)
      report_value("out_err_o", 32'(out_err), 32'(hold_err));
    if (ar_count != hold_ar)
    begin
      $display("[ERROR] %0t an AR was accepted while the output was stalled", $time);
      errors++;
    end
  endtask

  task automatic run_phase(input string name, input int count, input int ready_pct,
                           input int redir_pct);
    int first_hs;
    int first_miss;
    int first_err;
    first_hs   = hs_count;
    first_miss = miss_count;
    first_err  = errors;
    while (hs_count < first_hs + count)
    begin
      @(posedge clk);
      rng = xorshift32(rng);
      out_ready <= (rng % 100) < ready_pct;
      rng = xorshift32(rng);
      redirect    <= (rng % 100) < redir_pct;
      redirect_pc <= fetch_pkg::RESET_PC | {24'd0, rng[13:8], 2'b00}; // 64-word window.
    end
    $display("%s: %0d handshakes, %0d misses, %0d errors", name, hs_count - first_hs,
             miss_count - first_miss, errors - first_err);
  endtask

  // -------------------------------------------------------------------
  // Monitor, sampled on the falling edge
  // -------------------------------------------------------------------
  always @(negedge clk)
  begin
    if (rst)
    begin
      if (out_valid || arvalid || rready)
      begin
        $display("[ERROR] %0t outputs are active during reset", $time);
        errors++;
      end
    end
    else
    begin
      if (stalled)
        check_hold();
      if (arvalid && !arprot[2])
        report_value("m_axil_arprot_o[2]", 32'd0, 32'd1);
      if (out_valid && out_ready)
      begin
        check_fetch();
        exp_pc = redirect ? redirect_pc : (pend ? pend_pc : exp_pc + 32'd4);
        pend   = 1'b0;
      end
      else if (redirect)
      begin
        pend    = 1'b1;
        pend_pc = redirect_pc;
      end
      stalled   = out_valid && !out_ready;
      hold_inst = out_inst;
      hold_pc   = out_pc;
      hold_err  = out_err;
      hold_ar   = ar_count;
      if (stalled)
        stall_count++;
    end
  end

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(HS_BUDGET * CYC_PER_HS * CLK_PERIOD);
    $display("Watchdog expired after %0d handshakes", hs_count);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin
    $timeformat(-9, 0, " ns", 0);
    rng = 32'd78;
    rst         <= 1'b1;
    out_ready   <= 1'b0;
    redirect    <= 1'b0;
    redirect_pc <= fetch_pkg::RESET_PC;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    run_phase("sequential", 300, 100, 0);
    run_phase("redirect", 600, 100, 15);
    run_phase("backpressure", 600, 40, 10);
    if (conflict_count == 0 || fence_count == 0 || slverr_count == 0 || stall_count == 0)
    begin
      $display("Not every fetch case was exercised");
      errors++;
    end
    $write("total: %0d handshakes, %0d misses, %0d conflicts, %0d fences, %0d slverr, ",
           hs_count, miss_count, conflict_count, fence_count, slverr_count);
    $display("%0d stall cycles, %0d errors", stall_count, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- test/tb_axil_mem.sv
module tb_axil_mem (
  input  logic             clk,
  input  logic             rst,
  input  fetch_pkg::addr_t araddr_i,
  input  logic             arvalid_i,
  output logic             arready_o = 1'b0,
  output bus_pkg::data_t   rdata_o = '0,
  output bus_pkg::resp_t   rresp_o = bus_pkg::RESP_OKAY,
  output logic             rvalid_o = 1'b0,
  input  logic             rready_i,
  output int               ar_count_o = 0,
  output fetch_pkg::addr_t ar_addr_o = '0
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] rng;
  int unsigned delay;
  logic        busy;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Word 19 of every 32-word block holds fence.i.
  function automatic bus_pkg::data_t word_at(input fetch_pkg::addr_t a);
    if (a[6:2] == 5'd19)
      return fetch_pkg::FENCE_I;
    return xorshift32(a ^ 32'd78);
  endfunction

  function automatic logic err_range(input fetch_pkg::addr_t a);
    return a[31:5] == 27'h400_0006; // 0x800000c0 to 0x800000df.
  endfunction

  always @(posedge clk)
  begin
    if (rst)
    begin
      rng        <= 32'd78;
      delay      <= 0;
      busy       <= 1'b0;
      arready_o  <= 1'b0;
      rvalid_o   <= 1'b0;
      ar_count_o <= 0;
    end
    else
    begin
      arready_o <= 1'b0;
      if (!busy && arvalid_i && arready_o)
      begin
        busy       <= 1'b1;
        ar_addr_o  <= araddr_i;
        ar_count_o <= ar_count_o + 1;
        delay      <= rng % 6;
        rng        <= xorshift32(rng);
      end
      else if (!busy && arvalid_i)
      begin
        if (delay == 0)
          arready_o <= 1'b1;
        else
          delay <= delay - 1;
      end
      else if (busy && !rvalid_o)
      begin
        if (delay == 0)
        begin
          rvalid_o <= 1'b1;
          rdata_o  <= word_at(ar_addr_o);
          rresp_o  <= err_range(ar_addr_o) ? bus_pkg::RESP_SLVERR : bus_pkg::RESP_OKAY;
        end
        else
          delay <= delay - 1;
      end
      else if (rvalid_o && rready_i)
      begin
        rvalid_o <= 1'b0;
        busy     <= 1'b0;
        delay    <= rng % 6; // Latency of the next AR.
        rng      <= xorshift32(rng);
      end
    end
  end

endmodule

//--- rtl/fetch_top.sv
module fetch_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             redirect_i,
  input  fetch_pkg::addr_t redirect_pc_i,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output fetch_pkg::inst_t out_inst_o,
  output fetch_pkg::addr_t out_pc_o,
  output logic             out_err_o,
  output fetch_pkg::addr_t m_axil_araddr_o,
  output logic [2:0]       m_axil_arprot_o,
  output logic             m_axil_arvalid_o,
  input  logic             m_axil_arready_i,
  input  bus_pkg::data_t   m_axil_rdata_i,
  input  bus_pkg::resp_t   m_axil_rresp_i,
  input  logic             m_axil_rvalid_i,
  output logic             m_axil_rready_o
);

  fetch_pkg::addr_t pc;
  logic             pc_valid;
  logic             fire;
  logic             miss_req;
  fetch_pkg::addr_t miss_addr;
  logic             fill_valid;
  bus_pkg::data_t   fill_data;
  logic             fill_err;

  pc_gen pcg0 (
    .clk           (clk),
    .rst           (rst),
    .fire_i        (fire),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .pc_o          (pc),
    .pc_valid_o    (pc_valid)
  );

  icache_fetch icf0 (
    .clk          (clk),
    .rst          (rst),
    .pc_i         (pc),
    .pc_valid_i   (pc_valid),
    .miss_req_o   (miss_req),
    .miss_addr_o  (miss_addr),
    .fill_valid_i (fill_valid),
    .fill_data_i  (fill_data),
    .fill_err_i   (fill_err),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_inst_o   (out_inst_o),
    .out_pc_o     (out_pc_o),
    .out_err_o    (out_err_o),
    .fire_o       (fire)
  );

  axil_read_master arm0 (
    .clk              (clk),
    .rst              (rst),
    .miss_req_i       (miss_req),
    .miss_addr_i      (miss_addr),
    .fill_valid_o     (fill_valid),
    .fill_data_o      (fill_data),
    .fill_err_o       (fill_err),
    .m_axil_araddr_o  (m_axil_araddr_o),
    .m_axil_arprot_o  (m_axil_arprot_o),
    .m_axil_arvalid_o (m_axil_arvalid_o),
    .m_axil_arready_i (m_axil_arready_i),
    .m_axil_rdata_i   (m_axil_rdata_i),
    .m_axil_rresp_i   (m_axil_rresp_i),
    .m_axil_rvalid_i  (m_axil_rvalid_i),
    .m_axil_rready_o  (m_axil_rready_o)
  );

endmodule

//--- rtl/axil_read_master.sv
module axil_read_master (
  input  logic              clk,
  input  logic              rst,
  input  logic              miss_req_i,
  input  fetch_pkg::addr_t  miss_addr_i,
  output logic              fill_valid_o,
  output bus_pkg::data_t    fill_data_o,
  output logic              fill_err_o,
  output fetch_pkg::addr_t  m_axil_araddr_o,
  output logic [2:0]        m_axil_arprot_o,
  output logic              m_axil_arvalid_o,
  input  logic              m_axil_arready_i,
  input  bus_pkg::data_t    m_axil_rdata_i,
  input  bus_pkg::resp_t    m_axil_rresp_i,
  input  logic              m_axil_rvalid_i,
  output logic              m_axil_rready_o
);

  bus_pkg::rd_state_t state;

  assign m_axil_arprot_o  = 3'b100; // Instruction, secure, unprivileged.
  assign m_axil_arvalid_o = (state == bus_pkg::RD_ADDR);
  assign m_axil_rready_o  = (state == bus_pkg::RD_DATA);

  // Answer goes back in the cycle of the R beat.
  assign fill_valid_o = m_axil_rready_o && m_axil_rvalid_i;
  assign fill_data_o  = m_axil_rdata_i;
  assign fill_err_o   = (m_axil_rresp_i != bus_pkg::RESP_OKAY);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= bus_pkg::RD_IDLE;
    end
    else
    begin
      case (state)
        bus_pkg::RD_IDLE:
          if (miss_req_i)
            state <= bus_pkg::RD_ADDR;
        bus_pkg::RD_ADDR:
          if (m_axil_arready_i)
            state <= bus_pkg::RD_DATA;
        bus_pkg::RD_DATA:
          if (m_axil_rvalid_i)
            state <= bus_pkg::RD_IDLE;
        default:
          state <= bus_pkg::RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == bus_pkg::RD_IDLE && miss_req_i)
      m_axil_araddr_o <= miss_addr_i;
  end

  araddr_hold_a: assert property (@(posedge clk) disable iff (rst)
    m_axil_arvalid_o && !m_axil_arready_i |=> m_axil_arvalid_o && $stable(m_axil_araddr_o));

endmodule

//--- rtl/icache_fetch.sv
module icache_fetch (
  input  logic             clk,
  input  logic             rst,
  input  fetch_pkg::addr_t pc_i,
  input  logic             pc_valid_i,
  output logic             miss_req_o,
  output fetch_pkg::addr_t miss_addr_o,
  input  logic             fill_valid_i,
  input  bus_pkg::data_t   fill_data_i,
  input  logic             fill_err_i,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output fetch_pkg::inst_t out_inst_o,
  output fetch_pkg::addr_t out_pc_o,
  output logic             out_err_o,
  output logic             fire_o
);

  typedef enum logic [1:0] {
    LOOKUP,
    MISS,
    HOLD
  } state_t;

  state_t state;

  // -------------------------------------------------------------------
  // Line storage
  // -------------------------------------------------------------------
  fetch_pkg::inst_t             line_data [fetch_pkg::LINES];
  fetch_pkg::tag_t              line_tag  [fetch_pkg::LINES];
  logic [fetch_pkg::LINES-1:0]  line_valid;

  fetch_pkg::idx_t idx;
  fetch_pkg::tag_t tag;
  logic            hit;
  logic            load_hit;
  logic            load_fill;

  assign idx = pc_i[fetch_pkg::IDX_W+1:2];
  assign tag = pc_i[fetch_pkg::ADDR_W-1:fetch_pkg::IDX_W+2];
  assign hit = line_valid[idx] && (line_tag[idx] == tag);

  assign load_hit  = (state == LOOKUP) && pc_valid_i && hit;
  assign load_fill = (state == MISS) && fill_valid_i;

  assign miss_req_o  = (state == MISS);
  assign miss_addr_o = pc_i; // PC holds until the handshake.
  assign fire_o      = out_valid_o && out_ready_i;

  // -------------------------------------------------------------------
  // Control
  // -------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state       <= LOOKUP;
      out_valid_o <= 1'b0;
      line_valid  <= '0;
    end
    else
    begin
      case (state)
        LOOKUP:
        begin
          if (pc_valid_i)
          begin
            if (hit)
            begin
              out_valid_o <= 1'b1;
              state       <= HOLD;
            end
            else
            begin
              state <= MISS;
            end
          end
        end
        MISS:
        begin
          if (fill_valid_i)
          begin
            out_valid_o <= 1'b1;
            state       <= HOLD;
            if (!fill_err_i)
              line_valid[idx] <= 1'b1; // Error words stay uncached.
          end
        end
        HOLD:
        begin
          if (out_ready_i)
          begin
            out_valid_o <= 1'b0;
            state       <= LOOKUP;
            if (out_inst_o == fetch_pkg::FENCE_I)
              line_valid <= '0; // fence.i flush.
          end
        end
        default:
        begin
          state <= LOOKUP;
        end
      endcase
    end
  end

  // -------------------------------------------------------------------
  // Payload and refill
  // -------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (load_hit)
    begin
      out_inst_o <= line_data[idx];
      out_pc_o   <= pc_i;
      out_err_o  <= 1'b0;
    end
    else if (load_fill)
    begin
      out_inst_o <= fill_data_i;
      out_pc_o   <= pc_i;
      out_err_o  <= fill_err_i;
      if (!fill_err_i)
      begin
        line_data[idx] <= fill_data_i;
        line_tag[idx]  <= tag;
      end
    end
  end

  miss_addr_hold_a: assert property (@(posedge clk) disable iff (rst)
    miss_req_o && !fill_valid_i |=> miss_req_o && $stable(miss_addr_o));

  out_stable_a: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_inst_o)
      && $stable(out_pc_o) && $stable(out_err_o));

endmodule

//--- rtl/pc_gen.sv
module pc_gen (
  input  logic             clk,
  input  logic             rst,
  input  logic             fire_i,
  input  logic             redirect_i,
  input  fetch_pkg::addr_t redirect_pc_i,
  output fetch_pkg::addr_t pc_o,
  output logic             pc_valid_o
);

  logic             redir_pend;
  fetch_pkg::addr_t redir_pc;
  fetch_pkg::addr_t next_pc;

  // A redirect seen together with the handshake takes effect at once.
  always_comb
  begin
    if (redirect_i)
      next_pc = redirect_pc_i;
    else if (redir_pend)
      next_pc = redir_pc;
    else
      next_pc = pc_o + 32'd4;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_o       <= fetch_pkg::RESET_PC;
      pc_valid_o <= 1'b0;
      redir_pend <= 1'b0;
    end
    else
    begin
      pc_valid_o <= 1'b1;
      if (fire_i)
      begin
        pc_o       <= next_pc;
        redir_pend <= 1'b0; // Consumed.
      end
      else if (redirect_i)
      begin
        redir_pend <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (redirect_i && !fire_i)
      redir_pc <= redirect_pc_i;
  end

  pc_aligned_a: assert property (@(posedge clk) disable iff (rst)
    pc_valid_o |-> pc_o[1:0] == 2'b00);

endmodule

//--- rtl/bus_pkg.sv
package bus_pkg;

  localparam int DATA_W = 32;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [1:0]        resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } rd_state_t;

endpackage

//--- rtl/fetch_pkg.sv
package fetch_pkg;

  // -------------------------------------------------------------------
  // Fetch widths
  // -------------------------------------------------------------------
  localparam int ADDR_W = 32;
  localparam int INST_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [INST_W-1:0] inst_t;

  // -------------------------------------------------------------------
  // Cache geometry
  // -------------------------------------------------------------------
  localparam int IDX_W = 3;
  localparam int LINES = 1 << IDX_W;
  localparam int TAG_W = ADDR_W - IDX_W - 2; // Word offset is 2 bits.

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [TAG_W-1:0] tag_t;

  localparam addr_t RESET_PC = 32'h8000_0000;
  localparam inst_t FENCE_I  = 32'h0000_100f;

endpackage
